// File: Makefile
SIM := obj_dir/VrpDriveTb

all: run

$(SIM): filelist.f $(wildcard design/*.sv) $(wildcard verification/*.sv)
	verilator --binary --assert --timing -Wno-fatal --top-module rpDriveTb \
		-f filelist.f -o VrpDriveTb

run: $(SIM)
	./$(SIM) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "TB FAILED" sim.log; then echo "Simulation reported failure"; exit 1; fi
	@grep -q "TB PASSED" sim.log || (echo "Simulation did not complete"; exit 1)

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

// File: design/rpAddrRegs.sv
// Desired address registers
// DA and DC storage, geometry range check and one sector advance with carries
`timescale 1ns/10ps

module rpAddrRegs #(
   parameter int numSectors = 20,
   parameter int numTracks  = 19,
   parameter int numCyls    = 815
) (
   input  logic              clk,
   input  logic              rst,
   input  logic              wrDa,
   input  logic              wrDc,
   input  logic              advance,
   input  rpRegPkg::busWordT wrData,
   output rpRegPkg::daT      da,
   output rpRegPkg::dcT      dc,
   output logic              addrValid,
   output logic              aoe
);

   // Last position on each axis
   localparam logic [5:0] lastSector = 6'(numSectors - 1);
   localparam logic [4:0] lastTrack  = 5'(numTracks - 1);
   localparam logic [9:0] lastCyl    = 10'(numCyls - 1);

   logic sectorWrap;
   logic trackWrap;
   logic cylWrap;

   ////////////////////
   // Range check

   assign addrValid = (32'(da.sector) < numSectors) &&
                      (32'(da.track) < numTracks) &&
                      (32'(dc.cyl) < numCyls);

   // Carry chain
   assign sectorWrap = (da.sector == lastSector);
   assign trackWrap  = sectorWrap && (da.track == lastTrack);
   assign cylWrap    = trackWrap && (dc.cyl == lastCyl);

   // Overflow past the last cylinder
   assign aoe = advance && cylWrap;

   ////////////////////
   // Registers

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         da <= '0;
         dc <= '0;
      end
      else if (advance)
      begin
         // Next sector
         da.sector <= sectorWrap ? 6'd0 : da.sector + 6'd1;
         if (sectorWrap)
         begin
            da.track <= trackWrap ? 5'd0 : da.track + 5'd1;
         end
         if (trackWrap)
         begin
            dc.cyl <= cylWrap ? 10'd0 : dc.cyl + 10'd1;
         end
      end
      else
      begin
         // Software writes keep the reserved bits at zero
         if (wrDa)
         begin
            da.track  <= wrData.da.track;
            da.sector <= wrData.da.sector;
         end
         if (wrDc)
         begin
            dc.cyl <= wrData.dc.cyl;
         end
      end
   end

endmodule

// File: design/rpDrive.sv
// Disk drive register block
// Connects the bus slave, function control, address registers and ER1
`timescale 1ns/10ps

module rpDrive #(
   parameter int numSectors = 20,
   parameter int numTracks  = 19,
   parameter int numCyls    = 815,
   parameter int seekCycles = 12,
   parameter int xferCycles = 20
) (
   input  logic              clk,
   input  logic              rst,
   input  logic              cyc,
   input  logic              stb,
   input  logic              we,
   input  rpRegPkg::regAddrT adr,
   input  logic [15:0]       datWr,
   input  logic              writeLock,
   output logic [15:0]       datRd,
   output logic              ack,
   output logic              attn
);

   rpRegPkg::busWordT wrData;
   rpRegPkg::cs1T     cs1;
   rpRegPkg::er1T     er1;
   rpRegPkg::daT      da;
   rpRegPkg::dcT      dc;
   rpRegPkg::er1SetT  er1Set;

   logic wrCs1;
   logic wrEr1;
   logic wrDa;
   logic wrDc;
   logic dry;
   logic ata;
   logic drvClr;
   logic advance;
   logic addrValid;
   logic aoe;
   logic setRmr;
   logic setIlr;
   logic setIlf;
   logic setIae;
   logic setWle;

   // One bundle of set pulses from three sources
   assign er1Set = '{wle: setWle, iae: setIae, aoe: aoe, rmr: setRmr,
                     ilr: setIlr, ilf: setIlf};

   assign attn = ata;

   ////////////////////
   // Bus slave

   rpWbSlave i_rpWbSlave (
      .clk(clk), .rst(rst),
      .cyc(cyc), .stb(stb), .we(we), .adr(adr),
      .datWr(datWr), .datRd(datRd), .ack(ack),
      .dry(dry), .ata(ata), .cs1(cs1), .er1(er1), .da(da), .dc(dc),
      .writeLock(writeLock),
      .wrCs1(wrCs1), .wrEr1(wrEr1), .wrDa(wrDa), .wrDc(wrDc),
      .wrData(wrData), .setRmr(setRmr), .setIlr(setIlr)
   );

   ////////////////////
   // Drive logic

   rpFuncCtrl #(.seekCycles(seekCycles), .xferCycles(xferCycles)) i_rpFuncCtrl (
      .clk(clk), .rst(rst),
      .wrCs1(wrCs1), .wrData(wrData),
      .addrValid(addrValid), .writeLock(writeLock),
      .cs1(cs1), .dry(dry), .ata(ata),
      .drvClr(drvClr), .advance(advance),
      .setIlf(setIlf), .setIae(setIae), .setWle(setWle)
   );

   rpAddrRegs #(
      .numSectors(numSectors),
      .numTracks(numTracks),
      .numCyls(numCyls)
   ) i_rpAddrRegs (
      .clk(clk), .rst(rst),
      .wrDa(wrDa), .wrDc(wrDc), .advance(advance), .wrData(wrData),
      .da(da), .dc(dc), .addrValid(addrValid), .aoe(aoe)
   );

   rpError1 i_rpError1 (
      .clk(clk), .rst(rst),
      .drvClr(drvClr), .wrEr1(wrEr1), .wrData(wrData),
      .set(er1Set), .er1(er1)
   );

endmodule

// File: design/rpError1.sv
// Error register 1
// Sixteen error flags with software load, hardware set pulses and drive clear
`timescale 1ns/10ps

module rpError1 (
   input  logic              clk,
   input  logic              rst,
   input  logic              drvClr,
   input  logic              wrEr1,
   input  rpRegPkg::busWordT wrData,
   input  rpRegPkg::er1SetT  set,
   output rpRegPkg::er1T     er1
);

   ////////////////////
   // Set mask

   // Hardware settable bits spread into the register layout
   rpRegPkg::er1T setMask;

   // Value before set pulses are applied
   rpRegPkg::er1T baseVal;

   always_comb
   begin
      setMask      = '0;
      setMask.wle  = set.wle;
      setMask.iae  = set.iae;
      setMask.aoe  = set.aoe;
      setMask.rmr  = set.rmr;
      setMask.ilr  = set.ilr;
      setMask.ilf  = set.ilf;
   end

   // Software load replaces the old contents
   always_comb
   begin
      if (wrEr1)
      begin
         baseVal = wrData.er1;
      end
      else
      begin
         baseVal = er1;
      end
   end

   ////////////////////
   // Flag register

   // Clear beats set, set beats load
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         er1 <= '0;
      end
      else if (drvClr)
      begin
         er1 <= '0;
      end
      else
      begin
         // Set pulses force ones on top of the loaded or held value
         er1 <= baseVal | setMask;
      end
   end

endmodule

// File: design/rpFuncCtrl.sv
// Function control
// Decodes GO commands, times seeks and transfers, flags function errors and attention
`timescale 1ns/10ps

module rpFuncCtrl #(
   parameter int seekCycles = 12,
   parameter int xferCycles = 20
) (
   input  logic              clk,
   input  logic              rst,
   input  logic              wrCs1,
   input  rpRegPkg::busWordT wrData,
   input  logic              addrValid,
   input  logic              writeLock,
   output rpRegPkg::cs1T     cs1,
   output logic              dry,
   output logic              ata,
   output logic              drvClr,
   output logic              advance,
   output logic              setIlf,
   output logic              setIae,
   output logic              setWle
);

   // Counter sized for the longer operation
   localparam int maxCycles = (seekCycles > xferCycles) ? seekCycles : xferCycles;
   localparam int cntW      = $clog2(maxCycles + 1);

   localparam logic [cntW-1:0] seekLoad = cntW'(seekCycles - 1);
   localparam logic [cntW-1:0] xferLoad = cntW'(xferCycles - 1);

   rpFuncPkg::funcT fnReg;
   rpFuncPkg::cmdT  newCmd;
   rpFuncPkg::cmdT  curCmd;
   logic            busy;
   logic [cntW-1:0] busyCnt;
   logic            goCmd;
   logic            startOp;
   logic            opDone;
   logic            errSet;

   ////////////////////
   // Command decode

   // Incoming code from the bus, and the one held during busy
   assign newCmd = rpFuncPkg::decodeFunc(wrData.cs1.fn);
   assign curCmd = rpFuncPkg::decodeFunc(fnReg);

   assign goCmd = wrCs1 && wrData.cs1.go;

   // Error checks at GO
   assign setIlf = goCmd && !newCmd.legal;
   assign setIae = goCmd && (newCmd.isSeek || newCmd.isXfer) && !addrValid;
   assign setWle = goCmd && newCmd.isWrite && writeLock;
   assign errSet = setIlf || setIae || setWle;

   assign drvClr = goCmd && newCmd.isClr;

   // Only a clean seek or transfer makes the drive busy
   assign startOp = goCmd && (newCmd.isSeek || newCmd.isXfer) && !errSet;

   // Last busy cycle
   assign opDone  = busy && (busyCnt == '0);
   assign advance = opDone && curCmd.isXfer;

   ////////////////////
   // Busy timer

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         fnReg   <= rpFuncPkg::fnNop;
         busy    <= 1'b0;
         busyCnt <= '0;
      end
      else
      begin
         // Function field follows every CS1 write
         if (wrCs1)
         begin
            fnReg <= wrData.cs1.fn;
         end
         if (startOp)
         begin
            busy    <= 1'b1;
            busyCnt <= newCmd.isXfer ? xferLoad : seekLoad;
         end
         else if (opDone)
         begin
            busy <= 1'b0;
         end
         else if (busy)
         begin
            busyCnt <= busyCnt - 1'b1;
         end
      end
   end

   ////////////////////
   // Attention

   // Drive clear wins over any new cause
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         ata <= 1'b0;
      end
      else if (drvClr)
      begin
         ata <= 1'b0;
      end
      else if (errSet || (opDone && curCmd.isSeek))
      begin
         ata <= 1'b1;
      end
   end

   assign dry = !busy;

   // GO reads back as set while busy
   assign cs1 = '{rsv15to6: '0, fn: fnReg, go: busy};

endmodule

// File: design/rpFuncPkg.sv
// Drive function codes
// Code values, decoded command flags and the legal code rule
package rpFuncPkg;

   typedef logic [4:0] funcT;

   localparam funcT fnNop    = 5'd0;
   localparam funcT fnSeek   = 5'd2;
   localparam funcT fnDrvClr = 5'd4;
   localparam funcT fnWrite  = 5'd24;
   localparam funcT fnRead   = 5'd28;

   // Decoded command
   typedef struct packed {
      logic legal;
      logic isSeek;
      logic isXfer;
      logic isWrite;
      logic isClr;
   } cmdT;

   // Only the five codes above are defined
   function automatic logic isLegalFunc(funcT fn);
      return (fn == fnNop) || (fn == fnSeek) || (fn == fnDrvClr) ||
             (fn == fnWrite) || (fn == fnRead);
   endfunction

   function automatic cmdT decodeFunc(funcT fn);
      cmdT cmd;
      cmd.legal   = isLegalFunc(fn);
      cmd.isSeek  = (fn == fnSeek);
      // Read and write both move the heads over one sector
      cmd.isXfer  = (fn == fnRead) || (fn == fnWrite);
      cmd.isWrite = (fn == fnWrite);
      cmd.isClr   = (fn == fnDrvClr);
      return cmd;
   endfunction

endpackage

// File: design/rpRegPkg.sv
// Drive register definitions
// Register addresses, bit layouts, the bus word union and the ER1 set pulses
package rpRegPkg;

   ////////////////////
   // Register addresses

   // Word address on the slave port
   typedef logic [4:0] regAddrT;

   localparam regAddrT addrCs1 = 5'd0;
   localparam regAddrT addrDs  = 5'd1;
   localparam regAddrT addrEr1 = 5'd2;
   localparam regAddrT addrDa  = 5'd3;
   localparam regAddrT addrDc  = 5'd4;

   ////////////////////
   // Register layouts

   // Error register 1, MSB first
   typedef struct packed {
      logic dck;
      logic uns;
      logic iop;
      logic dte;
      logic wle;
      logic iae;
      logic aoe;
      logic hcrc;
      logic hce;
      logic ech;
      logic wcf;
      logic fer;
      logic par;
      logic rmr;
      logic ilr;
      logic ilf;
   } er1T;

   // Control and function
   typedef struct packed {
      logic [9:0] rsv15to6;
      logic [4:0] fn;
      logic       go;
   } cs1T;

   // Drive status, only the bits modeled here
   typedef struct packed {
      logic       ata;
      logic       err;
      logic [1:0] rsv13to12;
      logic       wrl;
      logic [2:0] rsv10to8;
      logic       dry;
      logic [6:0] rsv6to0;
   } dsT;

   // Desired track and sector
   typedef struct packed {
      logic [2:0] rsv15to13;
      logic [4:0] track;
      logic [1:0] rsv7to6;
      logic [5:0] sector;
   } daT;

   // Desired cylinder
   typedef struct packed {
      logic [5:0] rsv15to10;
      logic [9:0] cyl;
   } dcT;

   // One bus word seen through every register layout
   typedef union packed {
      logic [15:0] raw;
      cs1T         cs1;
      dsT          ds;
      er1T         er1;
      daT          da;
      dcT          dc;
   } busWordT;

   ////////////////////
   // Hardware set pulses for ER1

   typedef struct packed {
      logic wle;
      logic iae;
      logic aoe;
      logic rmr;
      logic ilr;
      logic ilf;
   } er1SetT;

endpackage

// File: design/rpWbSlave.sv
// Wishbone classic slave for the drive registers
// Ack generation, address decode, busy write gating and read data mux
`timescale 1ns/10ps

module rpWbSlave (
   input  logic              clk,
   input  logic              rst,
   input  logic              cyc,
   input  logic              stb,
   input  logic              we,
   input  rpRegPkg::regAddrT adr,
   input  logic [15:0]       datWr,
   output logic [15:0]       datRd,
   output logic              ack,
   input  logic              dry,
   input  logic              ata,
   input  rpRegPkg::cs1T     cs1,
   input  rpRegPkg::er1T     er1,
   input  rpRegPkg::daT      da,
   input  rpRegPkg::dcT      dc,
   input  logic              writeLock,
   output logic              wrCs1,
   output logic              wrEr1,
   output logic              wrDa,
   output logic              wrDc,
   output rpRegPkg::busWordT wrData,
   output logic              setRmr,
   output logic              setIlr
);

   logic              armed;
   logic              access;
   logic              wrAny;
   logic              mapped;
   logic              wrReg;
   rpRegPkg::busWordT rdWord;

   ////////////////////
   // Handshake

   // New cycle only after stb has dropped
   assign access = cyc && stb && armed;

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         ack   <= 1'b0;
         armed <= 1'b1;
      end
      else
      begin
         ack <= access;
         if (!stb)
         begin
            armed <= 1'b1;
         end
         else if (access)
         begin
            armed <= 1'b0;
         end
      end
   end

   ////////////////////
   // Write decode

   assign wrAny  = access && we;
   assign mapped = (adr <= rpRegPkg::addrDc);

   // Writable registers, DS excluded
   assign wrReg = (adr == rpRegPkg::addrCs1) || (adr == rpRegPkg::addrEr1) ||
                  (adr == rpRegPkg::addrDa) || (adr == rpRegPkg::addrDc);

   assign wrData.raw = datWr;

   // Strobes held off while busy
   assign wrCs1 = wrAny && dry && (adr == rpRegPkg::addrCs1);
   assign wrEr1 = wrAny && dry && (adr == rpRegPkg::addrEr1);
   assign wrDa  = wrAny && dry && (adr == rpRegPkg::addrDa);
   assign wrDc  = wrAny && dry && (adr == rpRegPkg::addrDc);

   // Refused write and illegal register
   assign setRmr = wrAny && !dry && wrReg;
   assign setIlr = access && !mapped;

   ////////////////////
   // Read mux

   always_comb
   begin
      rdWord.raw = '0;
      case (adr)
         rpRegPkg::addrCs1: rdWord.cs1 = cs1;
         rpRegPkg::addrDs:
         begin
            // Status built from live drive state
            rdWord.ds.ata = ata;
            rdWord.ds.err = |er1;
            rdWord.ds.wrl = writeLock;
            rdWord.ds.dry = dry;
         end
         rpRegPkg::addrEr1: rdWord.er1 = er1;
         rpRegPkg::addrDa:  rdWord.da  = da;
         rpRegPkg::addrDc:  rdWord.dc  = dc;
         default:           rdWord.raw = '0;
      endcase
   end

   // Captured with the ack edge
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         datRd <= '0;
      end
      else if (access)
      begin
         datRd <= rdWord.raw;
      end
   end

endmodule

// File: filelist.f
design/rpRegPkg.sv
design/rpFuncPkg.sv
design/rpError1.sv
design/rpAddrRegs.sv
design/rpFuncCtrl.sv
design/rpWbSlave.sv
design/rpDrive.sv
verification/rpDrive_asserts.sv
verification/rpDriveTb.sv

// File: verification/rpDriveTb.sv
// Drive register block testbench
// Bus tasks, LFSR stimulus, reference model with compare process and watchdog
`timescale 1ns/10ps

module rpDriveTb;

   // Bus accesses in the run, rounded up
   localparam int numOps = 200;

   logic        clk;
   logic        rst;
   logic        cyc;
   logic        stb;
   logic        we;
   logic [4:0]  adr;
   logic [15:0] datWr;
   logic        writeLock;
   logic [15:0] datRd;
   logic        ack;
   logic        attn;

   // Geometry and timing, taken from the DUT defaults
   int numSectors;
   int numTracks;
   int numCyls;
   int seekCycles;
   int xferCycles;

   int          edgeCnt = 0;
   int          errCount = 0;
   logic [31:0] lfsr = 32'h38d4;

   // Mirror state of the drive
   logic [4:0]  mFn;
   logic [15:0] mEr1;
   logic [15:0] mDa;
   logic [15:0] mDc;
   logic        mAta;
   logic        mBusy;
   logic        mOpXfer;
   int          mOpEnd;

   // Expected responses in access order
   logic [15:0] expQ[$];
   logic        attnQ[$];
   logic [4:0]  adrQ[$];
   logic [15:0] expData;
   logic        expAttn;
   logic [4:0]  expAdr;

   rpDrive i_rpDrive (
      .clk(clk), .rst(rst),
      .cyc(cyc), .stb(stb), .we(we), .adr(adr), .datWr(datWr),
      .writeLock(writeLock),
      .datRd(datRd), .ack(ack), .attn(attn)
   );

   ////////////////////
   // Clock and edge count

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // Label of each rising edge, used to place busy periods in time
   always @(posedge clk)
   begin
      edgeCnt <= edgeCnt + 1;
   end

   ////////////////////
   // Helpers

   task automatic failRun(input string msg);
      errCount++;
      $display("%s", msg);
      $display("TB FAILED");
      $fatal(1, "Run stopped at the first error");
   endtask

   task automatic checkVal(input string name, input logic [15:0] got, input logic [15:0] exp);
      assert (got === exp)
      else failRun($sformatf("ERR %s expected %h got %h", name, exp, got));
   endtask

   // Fibonacci LFSR, taps 32 22 2 1, one step per bit
   function automatic logic [31:0] randBits(int n);
      logic [31:0] v;
      logic        fb;
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
         lfsr = {lfsr[30:0], fb};
         v    = {v[30:0], fb};
      end
      return v;
   endfunction

   function automatic int randBelow(int limit);
      return int'(randBits(16)) % limit;
   endfunction

   // The five defined function codes
   function automatic logic codeDefined(logic [4:0] fn);
      return fn == 5'd0 || fn == 5'd2 || fn == 5'd4 || fn == 5'd24 || fn == 5'd28;
   endfunction

   ////////////////////
   // Reference model

   // One sector forward, carries into track and cylinder
   function automatic void finishOp();
      int sec;
      int trk;
      int cyl;
      mBusy = 1'b0;
      if (!mOpXfer)
      begin
         mAta = 1'b1;
         return;
      end
      sec = int'(mDa[5:0]) + 1;
      trk = int'(mDa[12:8]);
      cyl = int'(mDc[9:0]);
      if (sec == numSectors)
      begin
         sec = 0;
         trk++;
         if (trk == numTracks)
         begin
            trk = 0;
            cyl++;
            if (cyl == numCyls)
            begin
               cyl     = 0;
               mEr1[9] = 1'b1;
            end
         end
      end
      mDa = {3'b0, 5'(trk), 2'b0, 6'(sec)};
      mDc = {6'b0, 10'(cyl)};
   endfunction

   // Predicts datRd and attn for one access acked at edge edgeNo
   function automatic logic [15:0] refModel(input logic wr, input logic [4:0] a,
                                            input logic [15:0] d, input int edgeNo,
                                            output logic newAttn);
      logic [15:0] rd;
      logic        dryNow;
      logic [4:0]  fn;
      logic        posOk;
      logic        moves;
      logic        errHit;
      if (mBusy && edgeNo > mOpEnd)
      begin
         finishOp();
      end
      dryNow = !mBusy;
      // Read data is the state before the edge
      case (a)
         5'd0:    rd = {10'b0, mFn, mBusy};
         5'd1:    rd = {mAta, |mEr1, 2'b0, writeLock, 3'b0, dryNow, 7'b0};
         5'd2:    rd = mEr1;
         5'd3:    rd = mDa;
         5'd4:    rd = mDc;
         default: rd = '0;
      endcase
      if (a > 5'd4)
      begin
         mEr1[1] = 1'b1;
      end
      else if (wr && a != 5'd1)
      begin
         if (!dryNow)
         begin
            mEr1[2] = 1'b1;
         end
         else if (a == 5'd2)
         begin
            mEr1 = d;
         end
         else if (a == 5'd3)
         begin
            mDa = d & 16'h1f3f;
         end
         else if (a == 5'd4)
         begin
            mDc = d & 16'h03ff;
         end
         else
         begin
            mFn = d[5:1];
            fn  = d[5:1];
            // GO bit starts the function
            if (d[0])
            begin
               posOk  = int'(mDa[5:0]) < numSectors && int'(mDa[12:8]) < numTracks &&
                        int'(mDc[9:0]) < numCyls;
               moves  = fn == 5'd2 || fn == 5'd24 || fn == 5'd28;
               errHit = 1'b0;
               if (!codeDefined(fn))
               begin
                  mEr1[0] = 1'b1;
                  errHit  = 1'b1;
               end
               if (moves && !posOk)
               begin
                  mEr1[10] = 1'b1;
                  errHit   = 1'b1;
               end
               if (fn == 5'd24 && writeLock)
               begin
                  mEr1[11] = 1'b1;
                  errHit   = 1'b1;
               end
               if (errHit)
               begin
                  mAta = 1'b1;
               end
               else if (fn == 5'd4)
               begin
                  mEr1 = '0;
                  mAta = 1'b0;
               end
               else if (moves)
               begin
                  mBusy   = 1'b1;
                  mOpXfer = fn != 5'd2;
                  mOpEnd  = edgeNo + (mOpXfer ? xferCycles : seekCycles);
               end
            end
         end
      end
      // Busy period ending on this very edge
      if (mBusy && edgeNo == mOpEnd)
      begin
         finishOp();
      end
      newAttn = mAta;
      return rd;
   endfunction

   ////////////////////
   // Bus tasks

   // Starts and ends on a falling edge
   task automatic busCycle(input logic wr, input logic [4:0] a, input logic [15:0] d,
                           output logic [15:0] rd);
      logic [15:0] exp;
      logic        expA;
      int          waitCnt;
      exp = refModel(wr, a, d, edgeCnt + 1, expA);
      expQ.push_back(exp);
      attnQ.push_back(expA);
      adrQ.push_back(a);
      cyc     = 1'b1;
      stb     = 1'b1;
      we      = wr;
      adr     = a;
      datWr   = d;
      waitCnt = 0;
      do
      begin
         @(negedge clk);
         waitCnt++;
      end
      while (!ack && waitCnt < 4);
      assert (ack)
      else failRun("No ack came back for a bus access");
      // Ack belongs on the first edge after the request
      assert (waitCnt == 1)
      else failRun("Ack came later than the cycle after the request");
      rd  = datRd;
      cyc = 1'b0;
      stb = 1'b0;
      we  = 1'b0;
      // Idle cycle so the slave rearms
      @(negedge clk);
   endtask

   task automatic wbWrite(input logic [4:0] a, input logic [15:0] d);
      logic [15:0] unused;
      busCycle(1'b1, a, d, unused);
   endtask

   task automatic wbRead(input logic [4:0] a, output logic [15:0] rd);
      busCycle(1'b0, a, 16'h0000, rd);
   endtask

   task automatic goFunc(input logic [4:0] fn);
      wbWrite(rpRegPkg::addrCs1, {10'b0, fn, 1'b1});
   endtask

   task automatic setAddress(input int sec, input int trk, input int cyl);
      wbWrite(rpRegPkg::addrDa, {3'b0, 5'(trk), 2'b0, 6'(sec)});
      wbWrite(rpRegPkg::addrDc, {6'b0, 10'(cyl)});
   endtask

   // Poll DS until the drive is ready again
   task automatic waitReady();
      logic [15:0] ds;
      int          polls;
      polls = 0;
      wbRead(rpRegPkg::addrDs, ds);
      while (!ds[7])
      begin
         polls++;
         assert (polls <= seekCycles + xferCycles + 10)
         else failRun("Drive stayed busy beyond the poll limit");
         wbRead(rpRegPkg::addrDs, ds);
      end
   endtask

   ////////////////////
   // Compare process

   always @(negedge clk)
   begin
      if (!rst && ack)
      begin
         assert (expQ.size() != 0)
         else failRun("Ack seen with no access pending");
         expData = expQ.pop_front();
         expAttn = attnQ.pop_front();
         expAdr  = adrQ.pop_front();
         assert (datRd === expData)
         else failRun($sformatf("ERR datRd adr %h expected %h got %h", expAdr, expData, datRd));
         assert (attn === expAttn)
         else failRun($sformatf("ERR attn expected %h got %h", expAttn, attn));
      end
   end

   // Watchdog
   initial
   begin
      #(numOps * (i_rpDrive.xferCycles + 20) * 10);
      failRun("Watchdog expired before the tests finished");
   end

   ////////////////////
   // Tests

   initial
   begin
      logic [15:0] rd;
      logic [31:0] rnd;
      logic [4:0]  fn;
      int          sec;
      int          trk;
      int          cyl;
      numSectors = i_rpDrive.numSectors;
      numTracks  = i_rpDrive.numTracks;
      numCyls    = i_rpDrive.numCyls;
      seekCycles = i_rpDrive.seekCycles;
      xferCycles = i_rpDrive.xferCycles;
      {mFn, mEr1, mDa, mDc, mAta, mBusy, mOpXfer} = '0;
      mOpEnd    = 0;
      rst       = 1'b1;
      cyc       = 1'b0;
      stb       = 1'b0;
      we        = 1'b0;
      adr       = '0;
      datWr     = '0;
      writeLock = 1'b0;
      repeat (3) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;

      // Reset values and masked readback
      wbRead(rpRegPkg::addrDs, rd);
      checkVal("DS", rd, 16'h0080);
      checkVal("attn", {15'b0, attn}, 16'h0000);
      for (int a = 0; a < 5; a++)
      begin
         wbRead(5'(a), rd);
      end
      for (int i = 0; i < 8; i++)
      begin
         rnd = randBits(16);
         wbWrite(rpRegPkg::addrDa, rnd[15:0]);
         rnd = randBits(16);
         wbWrite(rpRegPkg::addrDc, rnd[15:0]);
         rnd = randBits(16);
         wbWrite(rpRegPkg::addrEr1, rnd[15:0]);
         wbRead(rpRegPkg::addrDa, rd);
         wbRead(rpRegPkg::addrDc, rd);
         wbRead(rpRegPkg::addrEr1, rd);
         wbRead(rpRegPkg::addrDs, rd);
      end
      goFunc(rpFuncPkg::fnDrvClr);

      // Unmapped registers
      for (int i = 0; i < 4; i++)
      begin
         wbRead(5'd5 + 5'(randBelow(27)), rd);
         rnd = randBits(16);
         wbWrite(5'd5 + 5'(randBelow(27)), rnd[15:0]);
      end
      wbRead(rpRegPkg::addrEr1, rd);
      checkVal("ER1.ilr", rd & 16'h0002, 16'h0002);

      // Undefined function code
      do
      begin
         fn = 5'(randBits(5));
      end
      while (codeDefined(fn));
      goFunc(fn);
      wbRead(rpRegPkg::addrEr1, rd);
      checkVal("ER1.ilf", rd & 16'h0001, 16'h0001);
      checkVal("attn", {15'b0, attn}, 16'h0001);
      goFunc(rpFuncPkg::fnDrvClr);
      wbRead(rpRegPkg::addrEr1, rd);
      checkVal("ER1", rd, 16'h0000);
      checkVal("attn", {15'b0, attn}, 16'h0000);

      // Seek to a valid random address
      sec = randBelow(numSectors);
      trk = randBelow(numTracks);
      cyl = randBelow(numCyls);
      setAddress(sec, trk, cyl);
      goFunc(rpFuncPkg::fnSeek);
      wbRead(rpRegPkg::addrDs, rd);
      checkVal("DS.dry", rd & 16'h0080, 16'h0000);
      waitReady();
      checkVal("attn", {15'b0, attn}, 16'h0001);
      wbRead(rpRegPkg::addrDa, rd);
      checkVal("DA", rd, {3'b0, 5'(trk), 2'b0, 6'(sec)});
      wbRead(rpRegPkg::addrDc, rd);
      goFunc(rpFuncPkg::fnDrvClr);

      // Register write during a seek
      goFunc(rpFuncPkg::fnSeek);
      rnd = randBits(16);
      wbWrite(rpRegPkg::addrDa, rnd[15:0]);
      waitReady();
      wbRead(rpRegPkg::addrDa, rd);
      checkVal("DA", rd, {3'b0, 5'(trk), 2'b0, 6'(sec)});
      wbRead(rpRegPkg::addrEr1, rd);
      checkVal("ER1.rmr", rd & 16'h0004, 16'h0004);
      goFunc(rpFuncPkg::fnDrvClr);

      // Sector out of range, then write lock
      setAddress(numSectors, 0, randBelow(numCyls));
      goFunc(rpFuncPkg::fnSeek);
      wbRead(rpRegPkg::addrDs, rd);
      checkVal("DS.dry", rd & 16'h0080, 16'h0080);
      wbRead(rpRegPkg::addrEr1, rd);
      checkVal("ER1.iae", rd & 16'h0400, 16'h0400);
      goFunc(rpFuncPkg::fnDrvClr);
      writeLock = 1'b1;
      setAddress(randBelow(numSectors), randBelow(numTracks), randBelow(numCyls));
      goFunc(rpFuncPkg::fnWrite);
      wbRead(rpRegPkg::addrEr1, rd);
      checkVal("ER1.wle", rd & 16'h0800, 16'h0800);
      wbRead(rpRegPkg::addrDs, rd);
      writeLock = 1'b0;
      goFunc(rpFuncPkg::fnDrvClr);

      // Reads from random addresses advance by one sector
      for (int i = 0; i < 4; i++)
      begin
         setAddress(randBelow(numSectors), randBelow(numTracks), randBelow(numCyls));
         goFunc(rpFuncPkg::fnRead);
         waitReady();
         wbRead(rpRegPkg::addrDa, rd);
         wbRead(rpRegPkg::addrDc, rd);
      end

      // Last sector of the disk wraps to zero
      setAddress(numSectors - 1, numTracks - 1, numCyls - 1);
      goFunc(rpFuncPkg::fnRead);
      waitReady();
      wbRead(rpRegPkg::addrDa, rd);
      checkVal("DA", rd, 16'h0000);
      wbRead(rpRegPkg::addrDc, rd);
      checkVal("DC", rd, 16'h0000);
      wbRead(rpRegPkg::addrEr1, rd);
      checkVal("ER1.aoe", rd & 16'h0200, 16'h0200);

      if (errCount == 0)
      begin
         $display("TB PASSED");
      end
      else
      begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule

// File: verification/rpDrive_asserts.sv
// Drive register block assertions
// Bus handshake rules and register protection while busy
`timescale 1ns/10ps

module rpDriveAsserts (
   input logic          clk,
   input logic          rst,
   input logic          cyc,
   input logic          stb,
   input logic          ack,
   input logic          dry,
   input logic          advance,
   input rpRegPkg::cs1T cs1,
   input rpRegPkg::daT  da,
   input rpRegPkg::dcT  dc
);

   // One cycle ack
   ackSingle: assert property (@(posedge clk) disable iff (rst) ack |=> !ack)
      else $error("ack held high for two cycles");

   // Ack answers a request from the previous cycle
   ackAfterStb: assert property (@(posedge clk) disable iff (rst)
      $rose(ack) |-> $past(cyc && stb))
      else $error("ack rose without a preceding cyc and stb");

   // Busy drive takes no register write, only the sector advance moves DA and DC
   noWriteBusy: assert property (@(posedge clk) disable iff (rst)
      !dry && !advance |=> $stable(da) && $stable(dc) && $stable(cs1.fn))
      else $error("register changed by a write while the drive is busy");

endmodule

bind rpDrive rpDriveAsserts i_rpDriveAsserts (
   .clk(clk), .rst(rst), .cyc(cyc), .stb(stb), .ack(ack), .dry(dry),
   .advance(advance), .cs1(cs1), .da(da), .dc(dc)
);
